/* hw/intc_config_table.sv */
`default_nettype none

module intc_config_table (
	input wire logic iCLOCK,
	input wire logic inRESET,
	// Table write port
	input wire logic ict_we,
	input wire intc_pkg::ict_write_t ict_wr,
	// Lookup for the current external line
	input wire logic [intc_pkg::EXT_NUM_W-1:0] ext_num,
	output logic allowed
);

	// One bit per entry for each field
	logic [intc_pkg::ICT_ENTRIES-1:0] valid;
	logic [intc_pkg::ICT_ENTRIES-1:0] mask;

	// Selected entry of the lookup
	logic entry_valid;
	logic entry_mask;

	// Valid bits always come out of reset cleared
	// so every line is allowed until configured
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			valid <= '0;
		end else if (ict_we) begin
			valid[ict_wr.entry] <= ict_wr.valid;
		end
	end

	// Mask storage is cleared on reset only when ICT_DATA_RESET_EN is set
	generate
		if (intc_pkg::ICT_DATA_RESET_EN) begin : g_mask_rst
			always_ff @(posedge iCLOCK or negedge inRESET) begin
				if (!inRESET) begin
					mask <= '0;
				end else if (ict_we) begin
					mask[ict_wr.entry] <= ict_wr.mask;
				end
			end
		end else begin : g_mask_norst
			always_ff @(posedge iCLOCK) begin
				if (ict_we) begin
					mask[ict_wr.entry] <= ict_wr.mask;
				end
			end
		end
	endgenerate

	// Combinational read of the addressed entry
	assign entry_valid = valid[ext_num];
	assign entry_mask = mask[ext_num];

	// An unconfigured entry lets the line through
	// a configured one passes only with its mask bit set
	assign allowed = !entry_valid || (entry_valid && entry_mask);

endmodule

`default_nettype wire

/* hw/intc_dispatch.sv */
`default_nettype none

module intc_dispatch (
	input wire logic iCLOCK,
	input wire logic inRESET,
	// Fault from the execution unit
	input wire intc_pkg::fault_req_t fault,
	// External side
	input wire logic ext_allowed_now,
	input wire logic [intc_pkg::EXT_NUM_W-1:0] ext_num,
	input wire intc_pkg::hw_req_t hw_req,
	// Exception manager side
	input wire logic exc_lock,
	input wire logic irq_ack,
	// Back to the latch and the source
	output logic hw_taken,
	output logic ext_ack,
	output intc_pkg::exc_out_t exc
);

	logic state;
	logic in_wait;

	// Held exception
	logic [intc_pkg::IRQ_NUM_W-1:0] num_q;
	logic [intc_pkg::FI0R_W-1:0] fi0r_q;
	logic ext_type_q;
	logic first_q;

	// Request qualification
	logic fault_go;
	logic hw_go;
	logic dispatch;
	logic live_ext;
	logic [intc_pkg::IRQ_NUM_W-1:0] ext_num_wide;

	assign in_wait = (state == intc_pkg::DISP_WAIT);

	// Lock blocks both sources
	assign fault_go = fault.active && !exc_lock;
	// Fault beats a latched external request
	assign hw_go = hw_req.valid && !exc_lock && !fault_go;

	assign dispatch = !in_wait && (fault_go || hw_go);

	// Latch is released in the cycle the request is chosen
	assign hw_taken = !in_wait && hw_go;

	// Unlocked external request seen before it reaches the latch
	assign live_ext = ext_allowed_now && !exc_lock;

	assign ext_num_wide = {{(intc_pkg::IRQ_NUM_W - intc_pkg::EXT_NUM_W){1'b0}}, ext_num};

	// IDLE/WAIT state machine
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= intc_pkg::DISP_IDLE;
		end else begin
			case (state)
				intc_pkg::DISP_IDLE: begin
					if (fault_go || hw_go) begin
						state <= intc_pkg::DISP_WAIT;
					end
				end
				intc_pkg::DISP_WAIT: begin
					// Manager has taken the exception
					if (irq_ack) begin
						state <= intc_pkg::DISP_IDLE;
					end
				end
				default: begin
					state <= intc_pkg::DISP_IDLE;
				end
			endcase
		end
	end

	// Capture of the chosen exception
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			num_q <= '0;
			fi0r_q <= '0;
			ext_type_q <= 1'b0;
		end else if (dispatch) begin
			if (fault_go) begin
				num_q <= fault.num;
				fi0r_q <= fault.fi0r;
				ext_type_q <= 1'b0;
			end else begin
				// External requests carry no fault information
				num_q <= hw_req.num;
				fi0r_q <= '0;
				ext_type_q <= 1'b1;
			end
		end
	end

	// Marks the first cycle of WAIT
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			first_q <= 1'b0;
		end else begin
			first_q <= dispatch;
		end
	end

	// One-cycle acknowledge for external dispatches only
	assign ext_ack = first_q && ext_type_q;

	// Look-ahead in IDLE and held value in WAIT
	always_comb begin
		exc.fi0r = fi0r_q;
		if (in_wait) begin
			exc.active = !irq_ack;
			exc.num = num_q;
		end else begin
			// A full latch shows up even while locked
			exc.active = fault_go || live_ext || hw_req.valid;
			exc.num = fault_go ? fault.num : ext_num_wide;
		end
	end

endmodule

`default_nettype wire

/* hw/intc_ext_latch.sv */
`default_nettype none

module intc_ext_latch (
	input wire logic iCLOCK,
	input wire logic inRESET,
	// External line from the source
	input wire logic ext_active,
	input wire logic [intc_pkg::EXT_NUM_W-1:0] ext_num,
	// Verdict of the table for ext_num
	input wire logic allowed,
	// Dispatcher has taken the held request
	input wire logic hw_taken,
	output logic ext_allowed_now,
	output intc_pkg::hw_req_t hw_req
);

	// Holding register
	logic held_valid;
	logic [intc_pkg::IRQ_NUM_W-1:0] held_num;

	// Zero-extended external number
	logic [intc_pkg::IRQ_NUM_W-1:0] ext_num_wide;

	// Capture condition
	logic capture;

	assign ext_num_wide = {{(intc_pkg::IRQ_NUM_W - intc_pkg::EXT_NUM_W){1'b0}}, ext_num};

	// Same-cycle request, already filtered by the table
	assign ext_allowed_now = ext_active && allowed;

	// Only an empty register takes a new request
	// anything arriving while full is dropped
	assign capture = !held_valid && ext_allowed_now;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			held_valid <= 1'b0;
		end else if (capture) begin
			held_valid <= 1'b1;
		end else if (hw_taken) begin
			held_valid <= 1'b0;
		end
	end

	// Number of the held request
	always_ff @(posedge iCLOCK) begin
		if (capture) begin
			held_num <= ext_num_wide;
		end
	end

	// Request towards the dispatcher
	always_comb begin
		hw_req.valid = held_valid;
		hw_req.num = held_num;
	end

endmodule

`default_nettype wire

/* hw/intc_pkg.sv */
`default_nettype none

package intc_pkg;

	// Interrupt configuration table geometry
	localparam int ICT_ENTRIES = 64;

	// External line number, also the table index
	localparam int EXT_NUM_W = 6;

	// Exception number seen by the exception manager
	localparam int IRQ_NUM_W = 7;

	// Fault information word width
	localparam int FI0R_W = 32;

	// Clear the mask bits as well on reset
	// Valid bits are cleared in any case
	localparam bit ICT_DATA_RESET_EN = 1'b1;

	// Dispatcher state encoding
	localparam logic DISP_IDLE = 1'b0;
	localparam logic DISP_WAIT = 1'b1;

	// One write into the configuration table
	typedef struct packed {
		logic [EXT_NUM_W-1:0] entry;
		logic mask;
		logic valid;
	} ict_write_t;

	// Synchronous fault from the execution unit
	typedef struct packed {
		logic active;
		logic [IRQ_NUM_W-1:0] num;
		logic [FI0R_W-1:0] fi0r;
	} fault_req_t;

	// Latched external request waiting for dispatch
	typedef struct packed {
		logic valid;
		logic [IRQ_NUM_W-1:0] num;
	} hw_req_t;

	// Exception presented to the exception manager
	typedef struct packed {
		logic active;
		logic [IRQ_NUM_W-1:0] num;
		logic [FI0R_W-1:0] fi0r;
	} exc_out_t;

endpackage

`default_nettype wire

/* hw/intc_top.sv */
`default_nettype none

module intc_top (
	input wire logic iCLOCK,
	input wire logic inRESET,
	// Configuration table write
	input wire logic ict_we,
	input wire intc_pkg::ict_write_t ict_wr,
	// Fault from the execution unit
	input wire intc_pkg::fault_req_t fault,
	// External interrupt line
	input wire logic ext_active,
	input wire logic [intc_pkg::EXT_NUM_W-1:0] ext_num,
	output logic ext_ack,
	// Exception manager
	input wire logic exc_lock,
	output intc_pkg::exc_out_t exc,
	input wire logic irq_ack
);

	// Table verdict for the current external number
	logic allowed;

	// Latch to dispatcher
	logic ext_allowed_now;
	intc_pkg::hw_req_t hw_req;

	// Dispatcher back to latch
	logic hw_taken;

	// Filter for the external line
	intc_config_table intc_config_table_inst (
		.iCLOCK (iCLOCK),
		.inRESET (inRESET),
		.ict_we (ict_we),
		.ict_wr (ict_wr),
		.ext_num (ext_num),
		.allowed (allowed)
	);

	// Holds one allowed request until dispatch
	intc_ext_latch intc_ext_latch_inst (
		.iCLOCK (iCLOCK),
		.inRESET (inRESET),
		.ext_active (ext_active),
		.ext_num (ext_num),
		.allowed (allowed),
		.hw_taken (hw_taken),
		.ext_allowed_now (ext_allowed_now),
		.hw_req (hw_req)
	);

	// Picks fault or external and talks to the manager
	intc_dispatch intc_dispatch_inst (
		.iCLOCK (iCLOCK),
		.inRESET (inRESET),
		.fault (fault),
		.ext_allowed_now (ext_allowed_now),
		.ext_num (ext_num),
		.hw_req (hw_req),
		.exc_lock (exc_lock),
		.irq_ack (irq_ack),
		.hw_taken (hw_taken),
		.ext_ack (ext_ack),
		.exc (exc)
	);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the interrupt controller testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_intc -Mdir obj_dir -f vlog.f
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/Vtb_intc > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "PASS: all tests" "$LOG"; then
	exit 0
fi
echo "Pass line not found in $LOG"
exit 1

/* sim/intc_asserts.sv */
`default_nettype none

module intc_asserts (
	input wire logic iCLOCK,
	input wire logic inRESET,
	input wire logic hw_taken,
	input wire logic ext_ack,
	input wire logic exc_lock,
	input wire intc_pkg::hw_req_t hw_req
);

	timeunit 1ns;
	timeprecision 1ps;

	// Failed assertions so far
	int fail_count = 0;

	// Source acknowledge is a single pulse
	ack_single_pulse: assert property (
		@(posedge iCLOCK) disable iff (!inRESET) ext_ack |=> !ext_ack
	) else begin
		fail_count++;
		$error("ext_ack stayed high for two cycles");
	end

	// Acknowledge only follows a taken latch entry
	ack_after_taken: assert property (
		@(posedge iCLOCK) disable iff (!inRESET) ext_ack |-> $past(hw_taken)
	) else begin
		fail_count++;
		$error("ext_ack without hw_taken in the previous cycle");
	end

	// Lock keeps the latched request in place
	no_take_locked: assert property (
		@(posedge iCLOCK) disable iff (!inRESET) exc_lock && hw_req.valid |=> hw_req.valid
	) else begin
		fail_count++;
		$error("latched request released while exc_lock is high");
	end

endmodule

`default_nettype wire

/* sim/tb_intc.sv */
`default_nettype none

module tb_intc;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int HALF_PERIOD = 10;
	localparam int RESET_CYCLES = 8;
	// Generous bound for one directed test
	localparam int TEST_CYCLES = 300;
	localparam int NUM_TESTS = 6;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_TESTS * TEST_CYCLES + 192;

	logic iCLOCK;
	logic inRESET;
	logic ict_we;
	intc_pkg::ict_write_t ict_wr;
	intc_pkg::fault_req_t fault;
	logic ext_active;
	logic [intc_pkg::EXT_NUM_W-1:0] ext_num;
	logic ext_ack;
	logic exc_lock;
	intc_pkg::exc_out_t exc;
	logic irq_ack;

	intc_top intc_top_inst (
		.iCLOCK (iCLOCK),
		.inRESET (inRESET),
		.ict_we (ict_we),
		.ict_wr (ict_wr),
		.fault (fault),
		.ext_active (ext_active),
		.ext_num (ext_num),
		.ext_ack (ext_ack),
		.exc_lock (exc_lock),
		.exc (exc),
		.irq_ack (irq_ack)
	);

	bind intc_dispatch intc_asserts intc_asserts_inst (.*);

	always #HALF_PERIOD iCLOCK = !iCLOCK;

	task automatic fail_now(string what);
		$display("%s", what);
		$display("FAIL: see errors above");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_eq(string test, string what, logic [39:0] expected,
			logic [39:0] actual);
		assert (actual === expected) else begin
			fail_now($sformatf("[FAIL] %s: %s expected %0h actual %0h",
				test, what, expected, actual));
		end
	endtask

	// Manager takes the exception and active drops at once
	task automatic ack_exception(string test);
		@(negedge iCLOCK);
		irq_ack = 1'b1;
		#1;
		check_eq(test, "active during irq_ack", 40'(1'b0), 40'(exc.active));
		@(negedge iCLOCK);
		irq_ack = 1'b0;
	endtask

	// Called just after a falling edge and leaves the exception unacknowledged
	task automatic wait_ext_ack(string test, logic [5:0] n);
		int cycles;
		cycles = 0;
		while (!ext_ack) begin
			if (cycles == 10) begin
				fail_now($sformatf("%s: ext_ack did not arrive within 10 cycles", test));
			end
			@(negedge iCLOCK);
			#1;
			cycles++;
		end
		check_eq(test, "held num", 40'({1'b0, n}), 40'(exc.num));
		check_eq(test, "held fi0r", 40'(0), 40'(exc.fi0r));
		check_eq(test, "active in wait", 40'(1'b1), 40'(exc.active));
		@(negedge iCLOCK);
		#1;
		check_eq(test, "ext_ack second cycle", 40'(1'b0), 40'(ext_ack));
	endtask

	task automatic dispatch_external(string test, logic [5:0] n);
		@(negedge iCLOCK);
		ext_active = 1'b1;
		ext_num = n;
		#1;
		check_eq(test, "look-ahead active", 40'(1'b1), 40'(exc.active));
		check_eq(test, "look-ahead num", 40'({1'b0, n}), 40'(exc.num));
		@(negedge iCLOCK);
		ext_active = 1'b0;
		#1;
		wait_ext_ack(test, n);
		ack_exception(test);
		#1;
		check_eq(test, "active back in idle", 40'(1'b0), 40'(exc.active));
	endtask

	task automatic write_entry(logic [5:0] n, logic mask, logic valid);
		@(negedge iCLOCK);
		ict_we = 1'b1;
		ict_wr.entry = n;
		ict_wr.mask = mask;
		ict_wr.valid = valid;
		@(negedge iCLOCK);
		ict_we = 1'b0;
	endtask

	task automatic test_reset();
		#1;
		check_eq("reset", "active", 40'(1'b0), 40'(exc.active));
		check_eq("reset", "ext_ack", 40'(1'b0), 40'(ext_ack));
		// Unconfigured entries let the line through
		dispatch_external("reset", 6'($urandom));
	endtask

	task automatic test_fault();
		logic [6:0] num;
		logic [31:0] info;
		num = 7'($urandom);
		info = $urandom;
		@(negedge iCLOCK);
		fault.active = 1'b1;
		fault.num = num;
		fault.fi0r = info;
		#1;
		check_eq("fault", "look-ahead num", 40'(num), 40'(exc.num));
		check_eq("fault", "look-ahead active", 40'(1'b1), 40'(exc.active));
		@(negedge iCLOCK);
		fault = '0;
		#1;
		repeat (3) begin
			check_eq("fault", "held num", 40'(num), 40'(exc.num));
			check_eq("fault", "held fi0r", 40'(info), 40'(exc.fi0r));
			check_eq("fault", "active", 40'(1'b1), 40'(exc.active));
			check_eq("fault", "ext_ack", 40'(1'b0), 40'(ext_ack));
			@(negedge iCLOCK);
			#1;
		end
		ack_exception("fault");
		#1;
		check_eq("fault", "active back in idle", 40'(1'b0), 40'(exc.active));
	endtask

	task automatic test_filter();
		logic [5:0] n;
		n = 6'($urandom);
		write_entry(n, 1'b0, 1'b1);
		ext_active = 1'b1;
		ext_num = n;
		repeat (20) begin
			#1;
			check_eq("filter", "masked active", 40'(1'b0), 40'(exc.active));
			check_eq("filter", "masked ext_ack", 40'(1'b0), 40'(ext_ack));
			@(negedge iCLOCK);
			ext_active = 1'b0;
		end
		write_entry(n, 1'b1, 1'b1);
		dispatch_external("filter", n);
	endtask

	task automatic test_priority();
		logic [5:0] n;
		logic [6:0] num;
		logic [31:0] info;
		n = 6'($urandom);
		num = 7'($urandom);
		info = $urandom;
		@(negedge iCLOCK);
		ext_active = 1'b1;
		ext_num = n;
		@(negedge iCLOCK);
		ext_active = 1'b0;
		exc_lock = 1'b1;
		fault.active = 1'b1;
		fault.num = num;
		fault.fi0r = info;
		#1;
		check_eq("priority", "locked active", 40'(1'b1), 40'(exc.active));
		@(negedge iCLOCK);
		exc_lock = 1'b0;
		#1;
		check_eq("priority", "fault chosen", 40'(num), 40'(exc.num));
		@(negedge iCLOCK);
		fault = '0;
		#1;
		check_eq("priority", "held fault num", 40'(num), 40'(exc.num));
		check_eq("priority", "held fault fi0r", 40'(info), 40'(exc.fi0r));
		check_eq("priority", "ext_ack on fault", 40'(1'b0), 40'(ext_ack));
		ack_exception("priority");
		#1;
		wait_ext_ack("priority", n);
		ack_exception("priority");
		#1;
		check_eq("priority", "active back in idle", 40'(1'b0), 40'(exc.active));
	endtask

	task automatic test_lock();
		logic [5:0] n;
		n = 6'($urandom);
		@(negedge iCLOCK);
		exc_lock = 1'b1;
		ext_active = 1'b1;
		ext_num = n;
		@(negedge iCLOCK);
		ext_active = 1'b0;
		ext_num = n ^ 6'h01;
		// Number follows the input as nothing is held
		repeat (10) begin
			#1;
			check_eq("lock", "active", 40'(1'b1), 40'(exc.active));
			check_eq("lock", "ext_ack", 40'(1'b0), 40'(ext_ack));
			check_eq("lock", "num", 40'({1'b0, n ^ 6'h01}), 40'(exc.num));
			@(negedge iCLOCK);
		end
		exc_lock = 1'b0;
		#1;
		wait_ext_ack("lock", n);
		ack_exception("lock");
		#1;
		check_eq("lock", "active back in idle", 40'(1'b0), 40'(exc.active));
	endtask

	initial begin
		#(WATCHDOG_CYCLES * 2 * HALF_PERIOD);
		$display("Watchdog expired before all tests finished");
		$display("FAIL: see errors above");
		$fatal(1, "timeout");
	end

	// Stop on the first failure of a bound assertion
	initial begin
		wait (intc_top_inst.intc_dispatch_inst.intc_asserts_inst.fail_count != 0);
		fail_now("A concurrent assertion on the dispatcher failed");
	end

	initial begin
		void'($urandom(32'h2a7879df));
		iCLOCK = 1'b0;
		inRESET = 1'b0;
		ict_we = 1'b0;
		ict_wr = '0;
		fault = '0;
		ext_active = 1'b0;
		ext_num = '0;
		exc_lock = 1'b0;
		irq_ack = 1'b0;
		repeat (RESET_CYCLES) @(negedge iCLOCK);
		inRESET = 1'b1;
		test_reset();
		test_fault();
		dispatch_external("external", 6'($urandom));
		test_filter();
		test_priority();
		test_lock();
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
hw/intc_pkg.sv
hw/intc_config_table.sv
hw/intc_ext_latch.sv
hw/intc_dispatch.sv
hw/intc_top.sv
sim/intc_asserts.sv
sim/tb_intc.sv
